/* design/fp16Pkg.sv */
`default_nettype none

package fp16Pkg;

   // fp16 field layout
   localparam int expWidth = 5;
   localparam int manWidth = 10;
   localparam int expBias = 15;

   // significand with the hidden bit in front
   localparam int sigWidth = manWidth + 1;

   typedef struct packed {
      logic sign;
      logic [expWidth-1:0] exponent;
      logic [manWidth-1:0] fraction;
   } fp16T;

   typedef enum logic [2:0] {
      clsZero,
      clsSubnormal,
      clsNormal,
      clsInfinity,
      clsNan
   } fpClassT;

   // unbiased exponent wide enough for sums from -48 up to +31
   typedef logic signed [7:0] expT;

   // full 11 by 11 significand product
   typedef logic [2*sigWidth-1:0] prodT;

   typedef struct packed {
      logic invalid;
      logic overflow;
      logic underflow;
      logic inexact;
   } fpFlagsT;

   // canonical quiet NaN returned for every NaN outcome
   localparam fp16T quietNan = 16'h7E00;

endpackage

`default_nettype wire

/* design/countLeadingZeros.sv */
`timescale 1ns/10ps
`default_nettype none

module countLeadingZeros
#(
   parameter int inWidth = 10
)
(
   input  wire logic [inWidth-1:0]               in,
   output logic      [$clog2(inWidth + 1) - 1:0] count
);

   localparam int countWidth = $clog2(inWidth + 1);

   // walk upward so the highest set bit has the final say
   always_comb
   begin
      count = countWidth'(inWidth);
      for (int i = 0; i < inWidth; i++)
      begin
         if (in[i])
         begin
            count = countWidth'(inWidth - 1 - i);
         end
      end

      // an all-zero input is the only case that reaches inWidth
      if (count == countWidth'(inWidth))
      begin
         assert (in == '0)
            else $error("leading zero count %0d for nonzero input %b", count, in);
      end
      else
      begin
         assert ((count < countWidth'(inWidth)) && in[inWidth-1-count]
                 && ((in >> (inWidth - count)) == '0))
            else $error("leading zero count %0d does not fit input %b", count, in);
      end
   end

endmodule

`default_nettype wire

/* design/fp16Unpack.sv */
`timescale 1ns/10ps
`default_nettype none

module fp16Unpack
(
   input  wire logic                           clk,
   input  wire logic                           reset,
   input  wire logic                           inValid,
   input  wire fp16Pkg::fp16T                  a,
   input  wire fp16Pkg::fp16T                  b,
   output logic                                unpValid,
   output logic                                signA,
   output logic                                signB,
   output fp16Pkg::fpClassT                    classA,
   output fp16Pkg::fpClassT                    classB,
   output fp16Pkg::expT                        expA,
   output fp16Pkg::expT                        expB,
   output logic [fp16Pkg::sigWidth-1:0]        sigA,
   output logic [fp16Pkg::sigWidth-1:0]        sigB
);

   import fp16Pkg::*;

   localparam int lzWidth = $clog2(manWidth + 1);

   logic [lzWidth-1:0] lzA;
   logic [lzWidth-1:0] lzB;

   function automatic fpClassT classOf(input fp16T x);
      if (x.exponent == '0)
      begin
         return (x.fraction == '0) ? clsZero : clsSubnormal;
      end
      if (x.exponent == '1)
      begin
         return (x.fraction == '0) ? clsInfinity : clsNan;
      end
      return clsNormal;
   endfunction

   // a subnormal moves its leading one up to the hidden position,
   // so its exponent drops by the same shift below -14
   function automatic expT expOf(input fp16T x, input logic [lzWidth-1:0] lz);
      if (x.exponent == '0)
      begin
         return expT'(1 - expBias) - expT'(lz) - expT'(1);
      end
      return expT'({3'b000, x.exponent}) - expT'(expBias);
   endfunction

   function automatic logic [sigWidth-1:0] sigOf(input fp16T x,
                                                 input logic [lzWidth-1:0] lz);
      if (x.exponent == '0)
      begin
         return {1'b0, x.fraction} << (lz + 1'b1);
      end
      return {1'b1, x.fraction};
   endfunction

   countLeadingZeros #(.inWidth(manWidth)) u_lzA (.in(a.fraction), .count(lzA));
   countLeadingZeros #(.inWidth(manWidth)) u_lzB (.in(b.fraction), .count(lzB));

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         unpValid <= 1'b0;
      end
      else
      begin
         unpValid <= inValid;
      end
   end

   always_ff @(posedge clk)
   begin
      if (inValid)
      begin
         signA  <= a.sign;
         signB  <= b.sign;
         classA <= classOf(a);
         classB <= classOf(b);
         expA   <= expOf(a, lzA);
         expB   <= expOf(b, lzB);
         sigA   <= sigOf(a, lzA);
         sigB   <= sigOf(b, lzB);
      end
   end

   // finite nonzero operands leave this stage with the hidden bit set
   assert property (@(posedge clk) disable iff (reset)
      unpValid && (classA inside {clsNormal, clsSubnormal}) |-> sigA[sigWidth-1]);
   assert property (@(posedge clk) disable iff (reset)
      unpValid && (classB inside {clsNormal, clsSubnormal}) |-> sigB[sigWidth-1]);

endmodule

`default_nettype wire

/* design/significandMultiply.sv */
`timescale 1ns/10ps
`default_nettype none

module significandMultiply
(
   input  wire logic                           clk,
   input  wire logic                           reset,
   input  wire logic                           unpValid,
   input  wire logic                           signA,
   input  wire logic                           signB,
   input  wire fp16Pkg::fpClassT               classA,
   input  wire fp16Pkg::fpClassT               classB,
   input  wire fp16Pkg::expT                   expA,
   input  wire fp16Pkg::expT                   expB,
   input  wire logic [fp16Pkg::sigWidth-1:0]   sigA,
   input  wire logic [fp16Pkg::sigWidth-1:0]   sigB,
   output logic                                mulValid,
   output logic                                mulSign,
   output fp16Pkg::expT                        mulExp,
   output fp16Pkg::prodT                       mulProd,
   output fp16Pkg::fpClassT                    mulSpecial,
   output logic                                mulInvalid
);

   import fp16Pkg::*;

   logic    anyNan;
   logic    anyInf;
   logic    anyZero;
   fpClassT specialNext;
   logic    invalidNext;

   assign anyNan  = (classA == clsNan) || (classB == clsNan);
   assign anyInf  = (classA == clsInfinity) || (classB == clsInfinity);
   assign anyZero = (classA == clsZero) || (classB == clsZero);

   // NaN wins over everything, then infinity times zero, then the rest
   always_comb
   begin
      specialNext = clsNormal;
      invalidNext = 1'b0;
      if (anyNan)
      begin
         specialNext = clsNan;
      end
      else if (anyInf && anyZero)
      begin
         specialNext = clsNan;
         invalidNext = 1'b1;
      end
      else if (anyInf)
      begin
         specialNext = clsInfinity;
      end
      else if (anyZero)
      begin
         specialNext = clsZero;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         mulValid <= 1'b0;
      end
      else
      begin
         mulValid <= unpValid;
      end
   end

   always_ff @(posedge clk)
   begin
      if (unpValid)
      begin
         mulSign    <= signA ^ signB;
         mulExp     <= expA + expB;
         mulProd    <= prodT'(sigA) * prodT'(sigB);
         mulSpecial <= specialNext;
         mulInvalid <= invalidNext;
      end
   end

endmodule

`default_nettype wire

/* design/roundPack.sv */
`timescale 1ns/10ps
`default_nettype none

module roundPack
(
   input  wire logic                  clk,
   input  wire logic                  reset,
   input  wire logic                  mulValid,
   input  wire logic                  mulSign,
   input  wire fp16Pkg::expT          mulExp,
   input  wire fp16Pkg::prodT         mulProd,
   input  wire fp16Pkg::fpClassT      mulSpecial,
   input  wire logic                  mulInvalid,
   output logic                       outValid,
   output fp16Pkg::fp16T              result,
   output fp16Pkg::fpFlagsT           flags
);

   import fp16Pkg::*;

   localparam int prodWidth = 2 * sigWidth;
   localparam int maxShift = 24;

   prodT                        normSig;
   logic signed [9:0]           biasedExp;
   logic                        isTiny;
   logic [4:0]                  shiftAmt;
   logic [prodWidth+maxShift-1:0] shiftWide;
   prodT                        alignedSig;
   logic                        guardBit;
   logic                        stickyBit;
   logic                        roundUp;
   logic                        isInexact;
   logic [expWidth-1:0]         expField;
   logic [expWidth+manWidth-1:0] magnitude;
   logic                        isOverflow;
   fp16T                        resultNext;
   fpFlagsT                     flagsNext;

   // the product lies in [1,4); bring its leading one up to bit 21
   always_comb
   begin
      if (mulProd[prodWidth-1])
      begin
         normSig   = mulProd;
         biasedExp = 10'(mulExp) + 10'(expBias) + 10'sd1;
      end
      else
      begin
         normSig   = {mulProd[prodWidth-2:0], 1'b0};
         biasedExp = 10'(mulExp) + 10'(expBias);
      end
   end

   assign isTiny = (biasedExp <= 10'sd0);

   always_comb
   begin
      if (!isTiny)
      begin
         shiftAmt = 5'd0;
      end
      else if (biasedExp < 10'sd1 - 10'(maxShift))
      begin
         shiftAmt = 5'(maxShift);
      end
      else
      begin
         shiftAmt = 5'(10'sd1 - biasedExp);
      end
   end

   // bits pushed out below the significand all land in the sticky part
   assign shiftWide  = {normSig, {maxShift{1'b0}}} >> shiftAmt;
   assign alignedSig = shiftWide[prodWidth+maxShift-1:maxShift];

   assign guardBit  = alignedSig[manWidth];
   assign stickyBit = (|alignedSig[manWidth-1:0]) || (|shiftWide[maxShift-1:0]);
   assign roundUp   = guardBit && (stickyBit || alignedSig[manWidth+1]);
   assign isInexact = guardBit || stickyBit;

   // a carry out of the fraction bumps the exponent field, which also
   // turns the largest subnormal into the smallest normal
   assign expField  = isTiny ? '0 : biasedExp[expWidth-1:0];
   assign magnitude = {expField, alignedSig[prodWidth-2:sigWidth]}
                      + (expWidth + manWidth)'(roundUp);

   assign isOverflow = !isTiny && ((biasedExp >= 10'sd31)
                       || (magnitude[expWidth+manWidth-1:manWidth] == '1));

   always_comb
   begin
      flagsNext = '0;
      case (mulSpecial)
         clsNan:
         begin
            resultNext        = quietNan;
            flagsNext.invalid = mulInvalid;
         end
         clsInfinity:
         begin
            resultNext = {mulSign, {expWidth{1'b1}}, {manWidth{1'b0}}};
         end
         clsZero:
         begin
            resultNext = {mulSign, {(expWidth + manWidth){1'b0}}};
         end
         default:
         begin
            if (isOverflow)
            begin
               resultNext         = {mulSign, {expWidth{1'b1}}, {manWidth{1'b0}}};
               flagsNext.overflow = 1'b1;
               flagsNext.inexact  = 1'b1;
            end
            else
            begin
               resultNext          = {mulSign, magnitude};
               flagsNext.inexact   = isInexact;
               flagsNext.underflow = isTiny && isInexact;
            end
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         outValid <= 1'b0;
      end
      else
      begin
         outValid <= mulValid;
      end
   end

   always_ff @(posedge clk)
   begin
      if (mulValid)
      begin
         result <= resultNext;
         flags  <= flagsNext;
      end
   end

   // the strobe chain from the input must stay clean all the way down
   assert property (@(posedge clk) disable iff (reset) !$isunknown(outValid));

endmodule

`default_nettype wire

/* design/fp16Multiplier.sv */
`timescale 1ns/10ps
`default_nettype none

module fp16Multiplier
(
   input  wire logic                clk,
   input  wire logic                reset,
   input  wire logic                inValid,
   input  wire fp16Pkg::fp16T       a,
   input  wire fp16Pkg::fp16T       b,
   output logic                     outValid,
   output fp16Pkg::fp16T            result,
   output fp16Pkg::fpFlagsT         flags
);

   import fp16Pkg::*;

   logic                unpValid;
   logic                signA;
   logic                signB;
   fpClassT             classA;
   fpClassT             classB;
   expT                 expA;
   expT                 expB;
   logic [sigWidth-1:0] sigA;
   logic [sigWidth-1:0] sigB;

   logic                mulValid;
   logic                mulSign;
   expT                 mulExp;
   prodT                mulProd;
   fpClassT             mulSpecial;
   logic                mulInvalid;

   fp16Unpack u_fp16Unpack (
      .clk      (clk),
      .reset    (reset),
      .inValid  (inValid),
      .a        (a),
      .b        (b),
      .unpValid (unpValid),
      .signA    (signA),
      .signB    (signB),
      .classA   (classA),
      .classB   (classB),
      .expA     (expA),
      .expB     (expB),
      .sigA     (sigA),
      .sigB     (sigB)
   );

   significandMultiply u_significandMultiply (
      .clk        (clk),
      .reset      (reset),
      .unpValid   (unpValid),
      .signA      (signA),
      .signB      (signB),
      .classA     (classA),
      .classB     (classB),
      .expA       (expA),
      .expB       (expB),
      .sigA       (sigA),
      .sigB       (sigB),
      .mulValid   (mulValid),
      .mulSign    (mulSign),
      .mulExp     (mulExp),
      .mulProd    (mulProd),
      .mulSpecial (mulSpecial),
      .mulInvalid (mulInvalid)
   );

   roundPack u_roundPack (
      .clk        (clk),
      .reset      (reset),
      .mulValid   (mulValid),
      .mulSign    (mulSign),
      .mulExp     (mulExp),
      .mulProd    (mulProd),
      .mulSpecial (mulSpecial),
      .mulInvalid (mulInvalid),
      .outValid   (outValid),
      .result     (result),
      .flags      (flags)
   );

endmodule

`default_nettype wire

/* testbench/fp16RefModel.svh */
`ifndef fp16RefModelSvh
`define fp16RefModelSvh

// operand value as an integer significand times a power of two
task automatic decodeOperand(input fp16T x, output longint man, output int expo);
   if (x.exponent == 5'd0)
   begin
      man  = longint'(x.fraction);
      expo = -24;
   end
   else
   begin
      man  = 1024 + longint'(x.fraction);
      expo = int'(x.exponent) - 25;
   end
endtask

// exact product first, then one rounding step to the fp16 quantum
task automatic refMultiply(input fp16T x, input fp16T y, output fp16T r, output fpFlagsT f);
   logic   s;
   logic   nanIn;
   logic   infIn;
   logic   zeroIn;
   logic   inexact;
   logic   tiny;
   longint ma;
   longint mb;
   longint prod;
   longint n;
   longint rem;
   longint half;
   int     ea;
   int     eb;
   int     e;
   int     top;
   int     p;
   int     q;
   int     sh;
   int     ef;
   s      = x.sign ^ y.sign;
   f      = '0;
   nanIn  = (x.exponent == 5'h1f && x.fraction != 0) || (y.exponent == 5'h1f && y.fraction != 0);
   infIn  = (x.exponent == 5'h1f && x.fraction == 0) || (y.exponent == 5'h1f && y.fraction == 0);
   zeroIn = (x[14:0] == 15'd0) || (y[14:0] == 15'd0);
   if (nanIn)
   begin
      r = 16'h7E00;
   end
   else if (infIn && zeroIn)
   begin
      r         = 16'h7E00;
      f.invalid = 1'b1;
   end
   else if (infIn)
   begin
      r = {s, 5'h1f, 10'h000};
   end
   else if (zeroIn)
   begin
      r = {s, 15'h0000};
   end
   else
   begin
      decodeOperand(x, ma, ea);
      decodeOperand(y, mb, eb);
      prod = ma * mb;
      e    = ea + eb;
      top  = 0;
      for (int i = 0; i < 32; i++)
      begin
         if (prod[i])
         begin
            top = i;
         end
      end
      // p is the weight of the leading one, q the weight of the last kept bit
      p = e + top;
      q = (p - 10 > -24) ? p - 10 : -24;
      sh = q - e;
      if (sh <= 0)
      begin
         n    = prod << (-sh);
         rem  = 0;
         half = 1;
      end
      else
      begin
         n    = prod >> sh;
         rem  = prod & ((longint'(1) << sh) - 1);
         half = longint'(1) << (sh - 1);
      end
      inexact = (rem != 0);
      tiny    = (p < -14);
      if (rem > half || (rem == half && n[0]))
      begin
         n++;
      end
      if (n == 2048)
      begin
         n = 1024;
         q++;
      end
      ef = (n < 1024) ? 0 : q + 25;
      if (ef >= 31)
      begin
         r          = {s, 5'h1f, 10'h000};
         f.overflow = 1'b1;
         f.inexact  = 1'b1;
      end
      else
      begin
         r           = {s, ef[4:0], n[9:0]};
         f.inexact   = inexact;
         f.underflow = tiny && inexact;
      end
   end
endtask

`endif

/* testbench/fp16MultiplierTb.sv */
`timescale 1ns/10ps
`default_nettype none

module fp16MultiplierTb;

   import fp16Pkg::*;

   `include "fp16RefModel.svh"

   localparam int waitLimit = 20;
   localparam int latency = 3;

   logic    clk;
   logic    reset;
   logic    inValid;
   fp16T    a;
   fp16T    b;
   logic    outValid;
   fp16T    result;
   fpFlagsT flags;

   int checkErrors;
   int otherErrors;
   int seed;

   fp16Multiplier u_fp16Multiplier (
      .clk      (clk),
      .reset    (reset),
      .inValid  (inValid),
      .a        (a),
      .b        (b),
      .outValid (outValid),
      .result   (result),
      .flags    (flags)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #4 clk = ~clk;
      end
   end

   task automatic checkResult(input string name, input fp16T expected, input fp16T actual);
      if (actual !== expected)
      begin
         $display("CHECK FAILED %s: expected result %h, actual %h", name, expected, actual);
         checkErrors++;
      end
   endtask

   task automatic checkFlags(input string name, input fpFlagsT expected, input fpFlagsT actual);
      if (actual !== expected)
      begin
         $display("CHECK FAILED %s: expected flags %b, actual %b", name, expected, actual);
         checkErrors++;
      end
   endtask

   task automatic checkStrobe(input string name, input logic expected, input logic actual);
      if (actual !== expected)
      begin
         $display("CHECK FAILED %s: expected outValid %b, actual %b", name, expected, actual);
         checkErrors++;
      end
   endtask

   task automatic checkLatency(input string name, input int expected, input int actual);
      if (actual != expected)
      begin
         $display("CHECK FAILED %s: expected latency %0d, actual %0d", name, expected, actual);
         checkErrors++;
      end
   endtask

   // one pair in, then wait for its strobe and count the cycles it took
   task automatic multiplyOnce(input string name, input fp16T x, input fp16T y,
                               input fp16T expResult, input fpFlagsT expFlags);
      int cycles;
      @(negedge clk);
      a       = x;
      b       = y;
      inValid = 1'b1;
      @(negedge clk);
      inValid = 1'b0;
      cycles  = 1;
      while (!outValid && cycles < waitLimit)
      begin
         @(negedge clk);
         cycles++;
      end
      if (!outValid)
      begin
         $display("%s: no result strobe within %0d cycles", name, waitLimit);
         otherErrors++;
      end
      else
      begin
         checkLatency(name, latency, cycles);
         checkResult(name, expResult, result);
         checkFlags(name, expFlags, flags);
      end
   endtask

   task automatic multiplyModelled(input string name, input fp16T x, input fp16T y);
      fp16T    r;
      fpFlagsT f;
      refMultiply(x, y, r, f);
      multiplyOnce(name, x, y, r, f);
   endtask

   task automatic resetAndLatency();
      reset   = 1'b1;
      inValid = 1'b0;
      repeat (16)
      begin
         @(negedge clk);
         checkStrobe("during reset", 1'b0, outValid);
      end
      reset = 1'b0;
      repeat (5)
      begin
         @(negedge clk);
         checkStrobe("idle after reset", 1'b0, outValid);
      end
      multiplyOnce("first strobe", 16'h3C00, 16'h3C00, 16'h3C00, 4'b0000);
   endtask

   task automatic exactNormals();
      multiplyOnce("1.5 times 2.0", 16'h3E00, 16'h4000, 16'h4200, 4'b0000);
      multiplyOnce("-3.0 times 0.5", 16'hC200, 16'h3800, 16'hBE00, 4'b0000);
      multiplyOnce("-2.0 times -2.0", 16'hC000, 16'hC000, 16'h4400, 4'b0000);
      multiplyModelled("7.0 times 9.0", 16'h4700, 16'h4880);
   endtask

   // one fraction bit at a time covers every leading zero count
   task automatic subnormalInputs();
      fp16T sub;
      for (int i = 0; i < 10; i++)
      begin
         sub = {1'b0, 5'd0, 10'(1 << i)};
         multiplyOnce($sformatf("subnormal bit %0d times 1.0", i), sub, 16'h3C00, sub, 4'b0000);
         multiplyModelled($sformatf("subnormal bit %0d times 2.0", i), sub, 16'h4000);
         multiplyModelled($sformatf("subnormal bit %0d times 1024", i), 16'h6400, sub);
         multiplyModelled($sformatf("subnormal bit %0d times -0.5", i), sub, 16'hB800);
      end
   endtask

   task automatic roundingCases();
      multiplyOnce("inexact round down", 16'h3C01, 16'h3C01, 16'h3C02, 4'b0001);
      multiplyOnce("tie to even up", 16'h3C01, 16'h3E00, 16'h3E02, 4'b0001);
      multiplyOnce("tie to even down", 16'h3C03, 16'h3E00, 16'h3E04, 4'b0001);
      multiplyOnce("carry into exponent", 16'h3FFE, 16'h3C01, 16'h4000, 4'b0001);
      multiplyModelled("inexact below one", 16'h3BFF, 16'h3BFF);
   endtask

   task automatic rangeLimits();
      multiplyOnce("overflow positive", 16'h7BFF, 16'h4000, 16'h7C00, 4'b0101);
      multiplyOnce("overflow negative", 16'hFBFF, 16'h4000, 16'hFC00, 4'b0101);
      multiplyOnce("round into overflow", 16'h7BFE, 16'h3C01, 16'h7C00, 4'b0101);
      multiplyOnce("exact subnormal", 16'h0400, 16'h3800, 16'h0200, 4'b0000);
      multiplyOnce("inexact subnormal", 16'h0401, 16'h3800, 16'h0200, 4'b0011);
      multiplyOnce("subnormal to normal", 16'h03FF, 16'h3C01, 16'h0400, 4'b0011);
      multiplyOnce("underflow to zero", 16'h0001, 16'h0001, 16'h0000, 4'b0011);
      multiplyOnce("underflow to -zero", 16'h8001, 16'h0001, 16'h8000, 4'b0011);
   endtask

   task automatic specialOperands();
      multiplyOnce("quiet NaN operand", 16'h7E00, 16'h3C00, 16'h7E00, 4'b0000);
      multiplyOnce("signalling NaN operand", 16'h3C00, 16'hFC01, 16'h7E00, 4'b0000);
      multiplyOnce("infinity times zero", 16'h7C00, 16'h0000, 16'h7E00, 4'b1000);
      multiplyOnce("infinity times -2.0", 16'h7C00, 16'hC000, 16'hFC00, 4'b0000);
      multiplyOnce("-zero times 1.0", 16'h8000, 16'h3C00, 16'h8000, 4'b0000);
      multiplyOnce("-zero times -zero", 16'h8000, 16'h8000, 16'h0000, 4'b0000);
   endtask

   // a new pair goes in every cycle and results pop in issue order
   task automatic randomStream(input int count);
      fp16T        expResults[$];
      fpFlagsT     expFlagSet[$];
      fp16T        x;
      fp16T        y;
      fp16T        r;
      fpFlagsT     f;
      logic [31:0] word;
      int          issued;
      int          received;
      int          idle;
      issued   = 0;
      received = 0;
      idle     = 0;
      while (received < count && idle < waitLimit)
      begin
         @(negedge clk);
         if (outValid)
         begin
            if (expResults.size() == 0)
            begin
               $display("random stream: result strobe with no pair in flight");
               otherErrors++;
            end
            else
            begin
               checkResult($sformatf("random pair %0d", received), expResults.pop_front(), result);
               checkFlags($sformatf("random pair %0d", received), expFlagSet.pop_front(), flags);
               received++;
            end
         end
         else if (issued == count)
         begin
            idle++;
         end
         if (issued < count)
         begin
            word = $random(seed);
            x    = word[15:0];
            word = $random(seed);
            y    = word[15:0];
            refMultiply(x, y, r, f);
            expResults.push_back(r);
            expFlagSet.push_back(f);
            a       = x;
            b       = y;
            inValid = 1'b1;
            issued++;
         end
         else
         begin
            inValid = 1'b0;
         end
      end
      if (received < count)
      begin
         $display("random stream: only %0d of %0d results arrived", received, count);
         otherErrors++;
      end
   endtask

   initial
   begin
      reset       = 1'b1;
      inValid     = 1'b0;
      a           = '0;
      b           = '0;
      checkErrors = 0;
      otherErrors = 0;
      seed        = 2;
      resetAndLatency();
      exactNormals();
      subnormalInputs();
      roundingCases();
      rangeLimits();
      specialOperands();
      randomStream(200);
      repeat (4) @(negedge clk);
      $display("errors: %0d check failures, %0d other failures", checkErrors, otherErrors);
      if (checkErrors == 0 && otherErrors == 0)
      begin
         $display("TESTS PASSED");
      end
      else
      begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* fp16Multiplier.f */
+incdir+testbench
design/fp16Pkg.sv
design/countLeadingZeros.sv
design/fp16Unpack.sv
design/significandMultiply.sv
design/roundPack.sv
design/fp16Multiplier.sv
testbench/fp16MultiplierTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the fp16 multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module fp16MultiplierTb -f fp16Multiplier.f -Mdir obj_dir \
   > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vfp16MultiplierTb > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log

grep -qx "TESTS PASSED" sim.log && exit 0 || exit 1
